// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_frontend
FILELIST = frontend.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== frontend.f ====
verilog/frontend_pkg.sv
verilog/decode_pkg.sv
verilog/inst_stream_if.sv
verilog/fifo_depth24.sv
verilog/ibuffer.sv
verilog/fetch_request.sv
verilog/inst_decode.sv
verilog/frontend_top.sv
testbench/frontend_checker.sv
testbench/tb_frontend.sv

// ==== testbench/frontend_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_checker
    import frontend_pkg::*;
    import decode_pkg::*;
(
    input  logic                clock,
    input  logic                reset_n,
    input  logic [31:0]         mem_words [1024],  // Model contents, word per pc/4
    input  logic                mem_req,
    input  logic [pc_width-1:0] mem_addr,
    input  logic                mem_done,
    input  logic                redirect,
    input  logic [pc_width-1:0] redirect_pc,
    input  logic                dec_valid,
    input  logic [pc_width-1:0] dec_pc,
    input  logic [6:0]          dec_opcode,
    input  logic [4:0]          dec_rd,
    input  logic [4:0]          dec_rs1,
    input  logic [4:0]          dec_rs2,
    input  logic [2:0]          dec_funct3,
    input  logic [6:0]          dec_funct7,
    input  logic [31:0]         dec_imm,
    input  logic [2:0]          dec_class,
    output int                  checked,        // Decoded instructions seen
    output int                  errors,
    output int                  imm_errors,
    output int                  redirect_hits,  // First pc after redirect was right
    output logic [7:0]          class_seen,
    output logic                busy            // Request outstanding
);

    logic [pc_width-1:0] expected_pc;
    logic                after_redirect;
    logic [pc_width-1:0] fetch_addr;            // Line the next request must name
    logic                stale;                 // Pending response is to be dropped
    decoded_inst_t       want;

    // Expected fields from the RV32I encodings
    function automatic decoded_inst_t ref_decode(input logic [31:0] w,
                                                 input logic [pc_width-1:0] pc);
        decoded_inst_t d;
        logic [12:0]   b_imm;
        logic [20:0]   j_imm;
        b_imm  = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        j_imm  = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        d.pc     = pc;
        d.opcode = w[6:0];
        d.rd     = w[11:7];
        d.funct3 = w[14:12];
        d.rs1    = w[19:15];
        d.rs2    = w[24:20];
        d.funct7 = w[31:25];
        d.imm        = 32'd0;          // R and illegal carry no immediate
        d.inst_class = class_illegal;
        if (w[6:0] == op_lui || w[6:0] == op_auipc) begin
            d.inst_class = class_u;
            d.imm        = {w[31:12], 12'd0};
        end else if (w[6:0] == op_jal) begin
            d.inst_class = class_j;
            d.imm        = {{11{j_imm[20]}}, j_imm};
        end else if (w[6:0] inside {op_jalr, op_load, op_imm, op_system}) begin
            d.inst_class = class_i;
            d.imm        = {{20{w[31]}}, w[31:20]};
        end else if (w[6:0] == op_branch) begin
            d.inst_class = class_b;
            d.imm        = {{19{b_imm[12]}}, b_imm};
        end else if (w[6:0] == op_store) begin
            d.inst_class = class_s;
            d.imm        = {{20{w[31]}}, w[31:25], w[11:7]};
        end else if (w[6:0] == op_reg) begin
            d.inst_class = class_r;
        end
        return d;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp_v);
        if (got !== exp_v) begin
            $display("ERROR %s: got %h expected %h at pc %h", name, got, exp_v, expected_pc);
            errors++;
        end
    endtask

    // Outputs sampled at the rising edge, before the DUT updates them
    always @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            expected_pc    = reset_pc;
            after_redirect = 1'b0;
            fetch_addr     = reset_pc;
            stale          = 1'b0;
            checked        = 0;
            errors         = 0;
            imm_errors     = 0;
            redirect_hits  = 0;
            class_seen     = '0;
            busy           = 1'b0;
        end else begin
            if (mem_req) begin
                compare("mem_addr", 64'(mem_addr), 64'(fetch_addr));
            end
            // Lines advance by 64 bytes unless the response is a stale one
            if (redirect) begin
                fetch_addr = redirect_pc;
                stale      = (busy || mem_req) && !mem_done;
            end else if (mem_done && busy) begin
                if (stale) begin
                    stale = 1'b0;
                end else begin
                    fetch_addr = fetch_addr + pc_width'(line_bytes);
                end
            end
            if (mem_done && busy) begin
                busy = 1'b0;
            end
            if (mem_req) begin
                if (busy) begin
                    $display("protocol error, mem_req raised while a request was outstanding");
                    errors++;
                end
                busy = 1'b1;
            end
            if (dec_valid) begin
                want = ref_decode(mem_words[expected_pc[11:2]], expected_pc);  // Wraps at 4 KB
                compare("dec_pc", 64'(dec_pc), 64'(want.pc));
                compare("dec_opcode", 64'(dec_opcode), 64'(want.opcode));
                compare("dec_rd", 64'(dec_rd), 64'(want.rd));
                compare("dec_rs1", 64'(dec_rs1), 64'(want.rs1));
                compare("dec_rs2", 64'(dec_rs2), 64'(want.rs2));
                compare("dec_funct3", 64'(dec_funct3), 64'(want.funct3));
                compare("dec_funct7", 64'(dec_funct7), 64'(want.funct7));
                compare("dec_class", 64'(dec_class), 64'(want.inst_class));
                if (dec_imm !== want.imm) begin
                    imm_errors++;
                end
                compare("dec_imm", 64'(dec_imm), 64'(want.imm));
                class_seen[dec_class] = 1'b1;
                if (after_redirect) begin
                    if (dec_pc == expected_pc) begin
                        redirect_hits++;
                    end
                    after_redirect = 1'b0;
                end
                checked++;
                expected_pc = expected_pc + pc_width'(4);
            end
            // Entry decoded at this edge still belongs to the old stream
            if (redirect) begin
                expected_pc    = redirect_pc;
                after_redirect = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frontend import frontend_pkg::*; import decode_pkg::*; ();

    localparam int stream_len   = 300;
    localparam int redirect_len = 40;    // Decoded after each redirect
    localparam int total_insts  = 2 * stream_len + 2 * redirect_len;
    localparam int cycle_limit  = 40 * total_insts + 200;

    // One of these every fifth word so all formats show up
    localparam logic [6:0] chosen_ops [10] = '{op_lui, op_auipc, op_jal, op_jalr, op_branch,
                                               op_load, op_store, op_imm, op_reg, op_system};

    logic                  clock;
    logic                  reset_n;
    logic                  redirect;
    logic [pc_width-1:0]   redirect_pc;
    logic                  mem_done;
    logic [line_width-1:0] mem_line;
    logic                  dec_stall;
    logic                  mem_req;
    logic [pc_width-1:0]   mem_addr;
    logic                  dec_valid;
    logic [pc_width-1:0]   dec_pc;
    logic [6:0]            dec_opcode;
    logic [4:0]            dec_rd;
    logic [4:0]            dec_rs1;
    logic [4:0]            dec_rs2;
    logic [2:0]            dec_funct3;
    logic [6:0]            dec_funct7;
    logic [31:0]           dec_imm;
    logic [2:0]            dec_class;

    logic [31:0]           mem_words [1024];
    logic [31:0]           lfsr_state;
    logic [31:0]           step_bits;
    logic [pc_width-1:0]   req_addr;
    logic                  stall_random;   // Random dec_stall on
    int                    wait_cycles;    // Memory latency left
    int                    cycle_count = 0;
    int                    tests_run = 0;
    int                    tests_passed = 0;
    int                    start_errors;
    int                    start_hits;
    int                    checked;
    int                    errors;
    int                    imm_errors;
    int                    redirect_hits;
    logic [7:0]            class_seen;
    logic                  busy;

    frontend_top i_frontend_top (.*);

    frontend_checker i_checker (.*);

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);   // Galois, right shift
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [line_width-1:0] line_at(input logic [pc_width-1:0] addr);
        logic [line_width-1:0] l;
        logic [9:0]            base;
        base = addr[11:2];                                  // Memory wraps at 1024 words
        for (int k = 0; k < line_insts; k++) begin
            l[k*32 +: 32] = mem_words[base + 10'(k)];
        end
        return l;
    endfunction

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // 4 ns period
    end

    // Memory model and random stall, one request at a time
    always @(negedge clock) begin
        mem_done = 1'b0;
        if (stall_random) begin
            step_bits = random_bits(1);
            dec_stall = step_bits[0];             // About half the cycles
        end else begin
            dec_stall = 1'b0;
        end
        if (wait_cycles != 0) begin
            wait_cycles--;
            if (wait_cycles == 0) begin
                mem_done = 1'b1;
                mem_line = line_at(req_addr);
            end
        end
        if (mem_req === 1'b1) begin
            req_addr    = mem_addr;
            step_bits   = random_bits(2);
            wait_cycles = 2 + int'(step_bits[1:0]);   // 2 to 5 cycles
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the decoded stream stopped", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic wait_decoded(input int n);
        int target;
        target = checked + n;
        while (checked < target) begin
            @(negedge clock);
        end
    endtask

    // Called at a falling edge
    task automatic pulse_redirect(input logic [pc_width-1:0] addr);
        redirect    = 1'b1;
        redirect_pc = addr;
        @(negedge clock);
        redirect    = 1'b0;
    endtask

    task automatic report_test(input string name, input logic ok);
        tests_run++;
        if (ok) begin
            tests_passed++;
        end
        $display("test %0d %s: %s, %0d decoded, %0d mismatches so far",
                 tests_run, name, ok ? "PASS" : "FAIL", checked, errors);
    endtask

    initial begin
        reset_n      = 1'b0;
        redirect     = 1'b0;
        redirect_pc  = '0;
        mem_done     = 1'b0;
        mem_line     = '0;
        dec_stall    = 1'b0;
        stall_random = 1'b0;
        wait_cycles  = 0;
        req_addr     = '0;
        lfsr_state   = 32'd10;
        for (int i = 0; i < 1024; i++) begin
            mem_words[i] = random_bits(32);
            if (i % 5 == 0) begin
                mem_words[i][6:0] = chosen_ops[(i / 5) % 10];
            end
        end
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        start_errors = errors;
        wait_decoded(stream_len);
        report_test("sequential stream", errors == start_errors);
        report_test("format coverage", class_seen[6:0] == 7'h7F && imm_errors == 0);

        start_errors = errors;
        @(posedge clock);
        stall_random = 1'b1;                      // Changed away from the falling edge
        wait_decoded(stream_len);
        @(posedge clock);
        stall_random = 1'b0;
        report_test("back-pressure", errors == start_errors);

        // Memory idle, nothing to discard
        start_errors = errors;
        start_hits   = redirect_hits;
        @(negedge clock);
        while (mem_req || busy) begin
            @(negedge clock);
        end
        pulse_redirect(48'h0000_1234_5640);
        wait_decoded(redirect_len);
        report_test("redirect mid-stream",
                    errors == start_errors && redirect_hits == start_hits + 1);

        // Request just issued, its line must be dropped
        start_errors = errors;
        start_hits   = redirect_hits;
        @(negedge clock);
        while (!mem_req) begin
            @(negedge clock);
        end
        pulse_redirect(48'h0000_0000_0A80);
        wait_decoded(redirect_len);
        report_test("redirect with response pending",
                    errors == start_errors && redirect_hits == start_hits + 1);

        $display("summary: %0d run, %0d passed, %0d mismatches over %0d decoded",
                 tests_run, tests_passed, errors, checked);
        if (tests_passed == tests_run && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    import frontend_pkg::*;

    // Major RV32I opcodes, bits 6:0
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_system = 7'b1110011;

    // Instruction format as seen by the decoder
    typedef enum logic [2:0] {
        class_u,
        class_j,
        class_i,
        class_b,
        class_s,
        class_r,
        class_illegal
    } inst_class_t;

    typedef struct packed {
        logic [pc_width-1:0] pc;
        logic [6:0]          opcode;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [2:0]          funct3;
        logic [6:0]          funct7;
        logic [31:0]         imm;        // Sign extended per format
        inst_class_t         inst_class;
    } decoded_inst_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_request.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_request import frontend_pkg::*; (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  fetch_inst,   // Refill pulse from the buffer
    input  logic                  redirect,
    input  logic [pc_width-1:0]   redirect_pc,  // Line aligned
    input  logic                  mem_done,
    input  logic [line_width-1:0] mem_line,
    output logic                  mem_req,      // One-cycle request pulse
    output logic [pc_width-1:0]   mem_addr,
    output logic                  can_fetch,
    output logic                  line_done,
    output logic [line_width-1:0] line,
    output logic [pc_width-1:0]   line_pc
);

    logic [pc_width-1:0] line_addr;     // Address of the line in flight or next
    logic                outstanding;   // Memory busy with our request
    logic                discard;       // Response belongs to a stale address

    assign mem_addr  = line_addr;
    assign can_fetch = !outstanding;
    assign line_done = mem_done && outstanding && !discard && !redirect;
    assign line      = mem_line;
    assign line_pc   = line_addr;       // Advances after the done edge

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            line_addr   <= reset_pc;
            outstanding <= 1'b0;
            discard     <= 1'b0;
            mem_req     <= 1'b0;
        end else begin
            mem_req <= 1'b0;
            if (redirect) begin
                line_addr <= redirect_pc;
                if (outstanding && !mem_done) begin
                    discard <= 1'b1;            // Wait for the old response
                end else begin
                    mem_req     <= 1'b1;        // Memory free, go now
                    outstanding <= 1'b1;
                    discard     <= 1'b0;
                end
            end else if (mem_done && outstanding) begin
                if (discard) begin
                    discard <= 1'b0;
                    mem_req <= 1'b1;            // Stale line dropped, reissue
                end else begin
                    outstanding <= 1'b0;
                    line_addr   <= line_addr + pc_width'(line_bytes);
                end
            end else if (fetch_inst && !outstanding) begin
                mem_req     <= 1'b1;
                outstanding <= 1'b1;
            end
        end
    end

    // Partial-line redirects are not supported
    assert property (@(posedge clock) disable iff (!reset_n)
        redirect |-> (redirect_pc[$clog2(line_bytes)-1:0] == '0))
        else $error("fetch_request: unaligned redirect_pc");

endmodule

`default_nettype wire

// ==== verilog/fifo_depth24.sv ====
`timescale 1ns/1ps
`default_nettype none

module fifo_depth24 import frontend_pkg::*; (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   clear,       // Flush, same edge
    input  ibuf_entry_t            data_in,
    input  logic                   write_en,
    input  logic                   read_en,
    output ibuf_entry_t            data_out,
    output logic                   data_valid,  // One cycle after accepted read
    output logic                   empty,
    output logic                   full,
    output logic [count_width-1:0] count
);

    ibuf_entry_t            storage [fifo_depth];
    logic [count_width-1:0] wr_ptr;
    logic [count_width-1:0] rd_ptr;
    logic                   wr_ok;
    logic                   rd_ok;

    assign empty = (count == '0);
    assign full  = (count == count_width'(fifo_depth));
    assign wr_ok = write_en && !full;
    assign rd_ok = read_en && !empty;

    // Payload path
    always_ff @(posedge clock) begin
        if (wr_ok) begin
            storage[wr_ptr] <= data_in;
        end
        if (rd_ok) begin
            data_out <= storage[rd_ptr];   // Head lands with data_valid
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            data_valid <= 1'b0;
        end else if (clear) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            data_valid <= 1'b0;            // Drops a read already in flight
        end else begin
            data_valid <= rd_ok;
            // Pointers wrap at the last slot, depth is not a power of two
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == count_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == count_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Both sides are expected to respect the flags
    assert property (@(posedge clock) disable iff (!reset_n) !(write_en && full))
        else $error("fifo_depth24: write while full");

    assert property (@(posedge clock) disable iff (!reset_n) !(read_en && empty))
        else $error("fifo_depth24: read while empty");

endmodule

`default_nettype wire

// ==== verilog/frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    localparam int pc_width    = 48;                      // Byte address width
    localparam int inst_width  = 32;
    localparam int line_insts  = 16;                      // Instructions per fetched line
    localparam int line_width  = line_insts * inst_width; // 512
    localparam int line_bytes  = line_width / 8;          // Address stride between lines
    localparam int fifo_depth  = 24;
    localparam int count_width = 5;                       // Enough for 0 to fifo_depth

    // Refill is asked for when the count drops below this
    localparam int refill_mark = 4;

    localparam logic [pc_width-1:0] reset_pc = '0;        // First line fetched

    // One buffered instruction with its byte address
    typedef struct packed {
        logic [inst_width-1:0] inst;
        logic [pc_width-1:0]   pc;
    } ibuf_entry_t;

endpackage

`default_nettype wire

// ==== verilog/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import frontend_pkg::*;
    import decode_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  redirect,      // Flush and restart fetch
    input  logic [pc_width-1:0]   redirect_pc,   // 64-byte aligned
    input  logic                  mem_done,
    input  logic [line_width-1:0] mem_line,
    input  logic                  dec_stall,
    output logic                  mem_req,
    output logic [pc_width-1:0]   mem_addr,
    output logic                  dec_valid,
    output logic [pc_width-1:0]   dec_pc,
    output logic [6:0]            dec_opcode,
    output logic [4:0]            dec_rd,
    output logic [4:0]            dec_rs1,
    output logic [4:0]            dec_rs2,
    output logic [2:0]            dec_funct3,
    output logic [6:0]            dec_funct7,
    output logic [31:0]           dec_imm,
    output logic [2:0]            dec_class
);

    logic                  fetch_inst;
    logic                  can_fetch;
    logic                  line_done;
    logic [line_width-1:0] line;
    logic [pc_width-1:0]   line_pc;
    decoded_inst_t         dec_out;

    inst_stream_if stream ();

    fetch_request i_fetch_request (
        .clock       (clock),
        .reset_n     (reset_n),
        .fetch_inst  (fetch_inst),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_done    (mem_done),
        .mem_line    (mem_line),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .can_fetch   (can_fetch),
        .line_done   (line_done),
        .line        (line),
        .line_pc     (line_pc)
    );

    ibuffer i_ibuffer (
        .clock      (clock),
        .reset_n    (reset_n),
        .clear      (redirect),
        .line_done  (line_done),
        .line       (line),
        .line_pc    (line_pc),
        .can_fetch  (can_fetch),
        .fetch_inst (fetch_inst),
        .stream     (stream.buffer)
    );

    inst_decode i_inst_decode (
        .clock     (clock),
        .reset_n   (reset_n),
        .clear     (redirect),
        .dec_stall (dec_stall),
        .stream    (stream.decoder),
        .dec_valid (dec_valid),
        .dec_out   (dec_out)
    );

    // Decoded struct out to flat ports
    assign dec_pc     = dec_out.pc;
    assign dec_opcode = dec_out.opcode;
    assign dec_rd     = dec_out.rd;
    assign dec_rs1    = dec_out.rs1;
    assign dec_rs2    = dec_out.rs2;
    assign dec_funct3 = dec_out.funct3;
    assign dec_funct7 = dec_out.funct7;
    assign dec_imm    = dec_out.imm;
    assign dec_class  = dec_out.inst_class;

endmodule

`default_nettype wire

// ==== verilog/ibuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ibuffer import frontend_pkg::*; (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  clear,       // Redirect flush
    input  logic                  line_done,   // Accepted line this cycle
    input  logic [line_width-1:0] line,
    input  logic [pc_width-1:0]   line_pc,
    input  logic                  can_fetch,   // No request outstanding
    output logic                  fetch_inst,  // Refill request pulse
    inst_stream_if.buffer         stream
);

    ibuf_entry_t                     line_entries [line_insts];
    logic [$clog2(line_insts)-1:0]   write_index;  // Next entry to push
    logic                            writing;      // Line still unloading
    logic                            write_en;
    logic                            fifo_full;
    logic [count_width-1:0]          fifo_count;
    logic [count_width-1:0]          count_prev;
    logic                            refill;

    assign write_en = writing && !fifo_full;   // Index holds while full

    fifo_depth24 i_fifo (
        .clock      (clock),
        .reset_n    (reset_n),
        .clear      (clear),
        .data_in    (line_entries[write_index]),
        .write_en   (write_en),
        .read_en    (stream.read_en),
        .data_out   (stream.entry),
        .data_valid (stream.valid),
        .empty      (stream.empty),
        .full       (fifo_full),
        .count      (fifo_count)
    );

    // Split the line, entry k sits at line_pc + 4k
    always_ff @(posedge clock) begin
        if (line_done) begin
            for (int k = 0; k < line_insts; k++) begin
                line_entries[k].inst <= line[k*inst_width +: inst_width];
                line_entries[k].pc   <= line_pc + pc_width'(k * (inst_width / 8));
            end
        end
    end

    // Count crossing the refill mark downwards, or the FIFO ran dry
    assign refill = ((count_prev == count_width'(refill_mark)) &&
                     (fifo_count == count_width'(refill_mark - 1))) || stream.empty;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            writing     <= 1'b0;
            write_index <= '0;
            count_prev  <= '0;
            fetch_inst  <= 1'b0;
        end else if (clear) begin
            writing     <= 1'b0;
            write_index <= '0;
            count_prev  <= '0;
            fetch_inst  <= 1'b0;
        end else begin
            count_prev <= fifo_count;
            if (line_done) begin
                writing     <= 1'b1;   // Writes start next cycle
                write_index <= '0;
            end else if (write_en) begin
                write_index <= write_index + 1'b1;
                if (&write_index) begin
                    writing <= 1'b0;   // Entry 15 pushed
                end
            end
            // Single-cycle pulse, never while a line is unloading
            fetch_inst <= refill && can_fetch && !writing && !line_done && !fetch_inst;
        end
    end

    // Fetch must not deliver a line on top of one still unloading
    assert property (@(posedge clock) disable iff (!reset_n) line_done |-> !writing)
        else $error("ibuffer: line_done while writer busy");

endmodule

`default_nettype wire

// ==== verilog/inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decode
    import frontend_pkg::*;
    import decode_pkg::*;
(
    input  logic           clock,
    input  logic           reset_n,
    input  logic           clear,       // Redirect flush
    input  logic           dec_stall,
    inst_stream_if.decoder stream,
    output logic           dec_valid,
    output decoded_inst_t  dec_out
);

    logic [inst_width-1:0] inst;
    decoded_inst_t         fields;

    assign inst = stream.entry.inst;

    // A pulsing valid means the single read in flight is landing
    assign stream.read_en = !dec_stall && !stream.empty && !stream.valid && !clear;

    always_comb begin
        fields.pc         = stream.entry.pc;
        fields.opcode     = inst[6:0];
        fields.rd         = inst[11:7];
        fields.funct3     = inst[14:12];
        fields.rs1        = inst[19:15];
        fields.rs2        = inst[24:20];
        fields.funct7     = inst[31:25];
        fields.imm        = '0;              // R type and illegal
        fields.inst_class = class_illegal;
        case (inst[6:0])
            op_lui, op_auipc: begin
                fields.inst_class = class_u;
                fields.imm        = {inst[31:12], 12'b0};
            end
            op_jal: begin
                fields.inst_class = class_j;
                fields.imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            op_jalr, op_load, op_imm, op_system: begin
                fields.inst_class = class_i;
                fields.imm        = {{20{inst[31]}}, inst[31:20]};
            end
            op_branch: begin
                fields.inst_class = class_b;
                fields.imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            op_store: begin
                fields.inst_class = class_s;
                fields.imm        = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            op_reg:  fields.inst_class = class_r;
            default: fields.inst_class = class_illegal;
        endcase
    end

    always_ff @(posedge clock) begin
        if (stream.valid) begin
            dec_out <= fields;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= stream.valid && !clear;   // Flush kills the entry in flight
        end
    end

    // Buffer must answer every read exactly one cycle later
    assert property (@(posedge clock) disable iff (!reset_n)
        stream.read_en |=> (stream.valid || $past(clear)))
        else $error("inst_decode: read not answered next cycle");

endmodule

`default_nettype wire

// ==== verilog/inst_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Buffered instructions from the buffer FIFO to the decoder
interface inst_stream_if import frontend_pkg::*; ();

    ibuf_entry_t entry;     // FIFO head, registered
    logic        valid;     // Pulses one cycle after an accepted read
    logic        read_en;   // Single-cycle pop, only while not empty
    logic        empty;

    modport buffer (
        output entry,
        output valid,
        output empty,
        input  read_en
    );

    modport decoder (
        input  entry,
        input  valid,
        input  empty,
        output read_en
    );

endinterface

`default_nettype wire
